// File: all.f
stomp_pkg.sv
miss_capture.sv
stream_dep_table.sv
rob_tag_store.sv
frontend_stomp.sv
rob_stomp.sv
stomp_top.sv
tb_stomp.sv

// File: Makefile
# Verilator build and run of the squash subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_stomp
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_stomp.sv
// directed tests only, fewer than 256 dispatches per run and all stage pcs word aligned
`timescale 1ns/10ps

module tb_stomp;
	import stomp_pkg::*;

	localparam int LEVELS = 4;
	localparam int WAIT_LIMIT = 50;

	logic         clk = 1'b0;
	logic         rst, advance;
	pc_t          fet_pc, ext_pc, dec_pc, ren_pc;
	stream_t      fet_stream, ext_stream, dec_stream, ren_stream;
	logic         disp_valid, ret_valid, fork_valid, free_valid;
	rob_ndx_t     disp_id, ret_id, miss_id, dest_id;
	stream_t      disp_stream, fork_parent, fork_child, free_stream, miss_stream;
	logic         miss_req, found_destination, miss_ack;
	pc_t          miss_pc;
	logic         stomp_fet, stomp_ext, stomp_dec, stomp_ren, stomp_que;
	rob_mask_t    rob_squash;

	// reference model of the ROB tags and of the fork table
	int           m_seq [16];
	stream_t      m_stream [16];
	logic [15:0]  m_valid;
	int           m_next;
	stream_mask_t m_dep [8];
	// order[k] is the entry that got the k-th dispatch of the last batch
	rob_ndx_t     order [16];
	int           checks, errors;

	stomp_top UUT (.*);

	always #4 clk = ~clk;

	// ====================================================================
	// model
	// ====================================================================

	// the miss stream and every stream forked from it, within the level limit
	function automatic stream_mask_t reach_of(stream_t s);
		stream_mask_t r;
		r = '0;
		if (s == 3'd0)
			return r;
		r[s] = 1'b1;
		repeat (LEVELS)
			for (int p = 1; p < 8; p++)
				if (r[p])
					r = r | m_dep[p];
		r[0] = 1'b0;
		return r;
	endfunction

	function automatic rob_mask_t expect_mask(rob_ndx_t br, rob_ndx_t dst, logic found,
		stream_t s);
		rob_mask_t m;
		stream_mask_t r;
		r = reach_of(s);
		for (int n = 0; n < 16; n++) begin
			// with a destination only the gap up to it is wrong path
			if (found)
				m[n] = m_seq[n] > m_seq[br] && m_seq[n] < m_seq[dst];
			else
				m[n] = m_seq[n] > m_seq[br] && m_stream[n] != m_stream[br];
			m[n] = m_valid[n] && (m[n] || r[m_stream[n]]);
		end
		return m;
	endfunction

	// ====================================================================
	// helpers
	// ====================================================================

	// inputs change 1 ns after the rising edge
	task automatic step;
		@(posedge clk);
		#1;
	endtask

	// outputs are looked at 3 ns after the edge, when every input has settled
	task automatic settle;
		#2;
	endtask

	task automatic check_eq(string what, logic [31:0] got, logic [31:0] want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, what, got, want);
		end
	endtask

	// bits are fet, ext, dec, ren, que
	task automatic check_front(string tag, logic [4:0] want);
		check_eq({tag, " stage squashes"},
			32'({stomp_fet, stomp_ext, stomp_dec, stomp_ren, stomp_que}), 32'(want));
	endtask

	// stream part of the stage squash, valid only while no stage flag is set
	task automatic check_stages(stream_mask_t r);
		check_eq("stage squash by stream",
			32'({stomp_fet, stomp_ext, stomp_dec, stomp_ren}),
			32'({r[fet_stream], r[ext_stream], r[dec_stream], r[ren_stream]}));
	endtask

	task automatic end_run;
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	endtask

	task automatic timed_out(string what);
		errors++;
		$display("timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
		end_run();
	endtask

	task automatic drive_pcs(pc_t f, pc_t e, pc_t d, pc_t r);
		fet_pc = f;
		ext_pc = e;
		dec_pc = d;
		ren_pc = r;
	endtask

	// returns in the first ack cycle, which is also the pulse cycle
	task automatic raise_miss(rob_ndx_t id, pc_t pc, stream_t s, logic found, rob_ndx_t dst);
		int n;
		miss_req = 1'b1;
		miss_id = id;
		miss_pc = pc;
		miss_stream = s;
		found_destination = found;
		dest_id = dst;
		n = 0;
		while (!miss_ack && n < WAIT_LIMIT) begin
			step();
			n++;
		end
		if (!miss_ack)
			timed_out("miss_ack rise");
		else
			check_eq("cycles from miss_req to miss_ack", n, 2);
	endtask

	task automatic drop_miss;
		int n;
		miss_req = 1'b0;
		n = 0;
		while (miss_ack && n < WAIT_LIMIT) begin
			step();
			n++;
		end
		if (miss_ack)
			timed_out("miss_ack fall");
		else
			check_eq("cycles from miss_req drop to miss_ack drop", n, 1);
	endtask

	// a random permutation decides the age order of all 16 entries
	task automatic dispatch_all(logic [17:0] pat);
		int j;
		rob_ndx_t t;
		for (int k = 0; k < 16; k++)
			order[k] = rob_ndx_t'(k);
		for (int k = 15; k > 0; k--) begin
			j = int'($urandom_range(k, 0));
			t = order[k];
			order[k] = order[j];
			order[j] = t;
		end
		disp_valid = 1'b1;
		for (int k = 0; k < 16; k++) begin
			disp_id = order[k];
			disp_stream = pat[3*(k%6) +: 3];
			m_seq[order[k]] = m_next;
			m_stream[order[k]] = disp_stream;
			m_valid[order[k]] = 1'b1;
			m_next++;
			step();
		end
		disp_valid = 1'b0;
	endtask

	task automatic retire_entry(rob_ndx_t id);
		ret_valid = 1'b1;
		ret_id = id;
		m_valid[id] = 1'b0;
		step();
		ret_valid = 1'b0;
	endtask

	task automatic add_fork(stream_t p, stream_t c);
		fork_valid = 1'b1;
		fork_parent = p;
		fork_child = c;
		m_dep[p][c] = 1'b1;
		step();
		fork_valid = 1'b0;
	endtask

	task automatic free_one(stream_t s);
		free_valid = 1'b1;
		free_stream = s;
		m_dep[s] = '0;
		for (int p = 0; p < 8; p++)
			m_dep[p][s] = 1'b0;
		step();
		free_valid = 1'b0;
	endtask

	// full exchange, mask checked one cycle after the pulse and gone the cycle after
	task automatic miss_and_mask(rob_ndx_t id, pc_t pc, stream_t s, logic found,
		rob_ndx_t dst, logic stages);
		rob_mask_t want;
		stream_mask_t r;
		raise_miss(id, pc, s, found, dst);
		want = expect_mask(id, dst, found, s);
		r = reach_of(s);
		settle();
		if (stages)
			check_stages(r);
		step();
		settle();
		check_eq("rob_squash after pulse", 32'(rob_squash), 32'(want));
		// the pulse drops the children of every squashed stream
		for (int p = 0; p < 8; p++)
			if (r[p])
				m_dep[p] = '0;
		if (stages)
			check_stages(reach_of(s));
		step();
		settle();
		check_eq("rob_squash one cycle later", 32'(rob_squash), 0);
		step();
		drop_miss();
	endtask

	// ====================================================================
	// tests
	// ====================================================================

	task automatic reset_state_check;
		settle();
		check_front("after reset", 5'b11111);
		check_eq("rob_squash after reset", 32'(rob_squash), 0);
		check_eq("miss_ack after reset", 32'(miss_ack), 0);
		step();
		// the reset target is odd, so aligned pcs never match it
		advance = 1'b1;
		for (int k = 0; k < 3; k++) begin
			drive_pcs($urandom & 32'hffff_fffc, $urandom & 32'hffff_fffc,
				$urandom & 32'hffff_fffc, $urandom & 32'hffff_fffc);
			settle();
			check_front("advance without target", 5'b11111);
			step();
		end
		advance = 1'b0;
	endtask

	task automatic rob_no_dest;
		dispatch_all({3'd1, 3'd2, 3'd1, 3'd1, 3'd2, 3'd1});
		retire_entry(order[2]);
		retire_entry(order[10]);
		miss_and_mask(order[5], $urandom & 32'hffff_fffc, 3'd0, 1'b0, 4'd0, 1'b0);
	endtask

	task automatic waterfall_walk;
		pc_t t;
		pc_t p [4];
		pc_t q [4];
		t = $urandom & 32'h00ff_fff0;
		for (int i = 0; i < 4; i++)
			p[i] = t + 32'h100 * (i + 1);
		drive_pcs(p[0], p[1], p[2], p[3]);
		advance = 1'b0;
		raise_miss(4'd0, t, 3'd0, 1'b0, 4'd0);
		drop_miss();
		settle();
		check_front("flags set by miss", 5'b11111);
		step();
		// while stalled the target group in fetch is kept but the flag stays
		fet_pc = t;
		settle();
		check_front("target in stalled fetch", 5'b01111);
		step();
		fet_pc = p[0];
		settle();
		check_front("stall keeps fetch flag", 5'b11111);
		step();
		// the target group walks down one stage per advance
		advance = 1'b1;
		for (int k = 0; k < 5; k++) begin
			for (int i = 0; i < 4; i++)
				q[i] = (k >= i) ? t + 32'(4 * (k - i)) : p[i];
			drive_pcs(q[0], q[1], q[2], q[3]);
			settle();
			check_front($sformatf("waterfall step %0d", k), {1'b0, k < 1, k < 2, k < 3, k < 4});
			step();
		end
		advance = 1'b0;
		drive_pcs(p[0], p[1], p[2], p[3]);
		repeat (2) begin
			settle();
			check_front("stall after waterfall", 5'b00000);
			step();
		end
		// a new miss raises every flag again, the queue stage waits for an advance
		raise_miss(4'd0, t + 32'h80, 3'd0, 1'b0, 4'd0);
		drop_miss();
		settle();
		check_front("flags set again by miss", 5'b11110);
		step();
		// the new target sits in every stage, so one advance clears all flags
		drive_pcs(t + 32'h80, t + 32'h80, t + 32'h80, t + 32'h80);
		advance = 1'b1;
		settle();
		check_front("new target in every stage", 5'b00000);
		step();
		advance = 1'b0;
	endtask

	task automatic rob_with_dest;
		dispatch_all({6{3'd1}});
		retire_entry(order[6]);
		miss_and_mask(order[3], $urandom & 32'hffff_fffc, 3'd0, 1'b1, order[9], 1'b1);
	endtask

	task automatic handshake_timing;
		int pulses;
		pulses = 0;
		raise_miss(order[0], $urandom & 32'hffff_fffc, 3'd0, 1'b1, order[15]);
		// a changed report while ack is high must not be taken again
		miss_pc = miss_pc ^ 32'h40;
		found_destination = 1'b0;
		for (int k = 0; k < 4; k++) begin
			step();
			settle();
			check_eq("miss_ack held while miss_req high", 32'(miss_ack), 1);
			if (rob_squash != '0)
				pulses++;
		end
		check_eq("squash pulses for one request", pulses, 1);
		step();
		drop_miss();
		// a new request right after the ack fell is taken normally
		raise_miss(order[0], $urandom & 32'hffff_fffc, 3'd0, 1'b1, order[15]);
		drop_miss();
	endtask

	task automatic stream_closure;
		add_fork(3'd2, 3'd3);
		add_fork(3'd3, 3'd4);
		add_fork(3'd2, 3'd5);
		add_fork(3'd1, 3'd6);
		free_one(3'd5);
		dispatch_all({3'd6, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1});
		fet_stream = 3'd3;
		ext_stream = 3'd4;
		dec_stream = 3'd5;
		ren_stream = 3'd6;
		miss_and_mask(order[0], $urandom & 32'hffff_fffc, 3'd2, 1'b1, order[1], 1'b1);
	endtask

	// ====================================================================
	// main sequence
	// ====================================================================

	initial begin
		void'($urandom(83));
		checks = 0;
		errors = 0;
		m_next = 0;
		m_valid = '0;
		for (int p = 0; p < 8; p++)
			m_dep[p] = '0;
		rst = 1'b1;
		advance = 1'b0;
		drive_pcs('0, '0, '0, '0);
		fet_stream = '0;
		ext_stream = '0;
		dec_stream = '0;
		ren_stream = '0;
		disp_valid = 1'b0;
		disp_id = '0;
		disp_stream = '0;
		ret_valid = 1'b0;
		ret_id = '0;
		fork_valid = 1'b0;
		fork_parent = '0;
		fork_child = '0;
		free_valid = 1'b0;
		free_stream = '0;
		miss_req = 1'b0;
		miss_id = '0;
		miss_pc = '0;
		miss_stream = '0;
		found_destination = 1'b0;
		dest_id = '0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		reset_state_check();
		rob_no_dest();
		waterfall_walk();
		rob_with_dest();
		handshake_timing();
		stream_closure();
		end_run();
	end

endmodule

// File: stomp_top.sv
// only the branch-unit miss report uses a handshake, every other input is taken as valid in the cycle it is high
`timescale 1ns/10ps

module stomp_top #(
	parameter int ROB_ENTRIES   = stomp_pkg::ROB_ENTRIES,
	parameter int XSTREAMS      = stomp_pkg::XSTREAMS,
	parameter int BRANCH_LEVELS = stomp_pkg::BRANCH_LEVELS
) (
	input  logic                 clk,
	input  logic                 rst,
	// pipeline stages
	input  logic                 advance,
	input  stomp_pkg::pc_t       fet_pc,
	input  stomp_pkg::stream_t   fet_stream,
	input  stomp_pkg::pc_t       ext_pc,
	input  stomp_pkg::stream_t   ext_stream,
	input  stomp_pkg::pc_t       dec_pc,
	input  stomp_pkg::stream_t   dec_stream,
	input  stomp_pkg::pc_t       ren_pc,
	input  stomp_pkg::stream_t   ren_stream,
	// dispatch and retire
	input  logic                 disp_valid,
	input  stomp_pkg::rob_ndx_t  disp_id,
	input  stomp_pkg::stream_t   disp_stream,
	input  logic                 ret_valid,
	input  stomp_pkg::rob_ndx_t  ret_id,
	// stream fork and free
	input  logic                 fork_valid,
	input  stomp_pkg::stream_t   fork_parent,
	input  stomp_pkg::stream_t   fork_child,
	input  logic                 free_valid,
	input  stomp_pkg::stream_t   free_stream,
	// miss report from the branch unit
	input  logic                 miss_req,
	input  stomp_pkg::rob_ndx_t  miss_id,
	input  stomp_pkg::pc_t       miss_pc,
	input  stomp_pkg::stream_t   miss_stream,
	input  logic                 found_destination,
	input  stomp_pkg::rob_ndx_t  dest_id,
	output logic                 miss_ack,
	// squash outputs
	output logic                 stomp_fet,
	output logic                 stomp_ext,
	output logic                 stomp_dec,
	output logic                 stomp_ren,
	output logic                 stomp_que,
	output stomp_pkg::rob_mask_t rob_squash
);
	import stomp_pkg::*;

	// latched miss report
	logic         miss_pulse;
	rob_ndx_t     miss_id_q;
	pc_t          miss_pc_q;
	stream_t      miss_stream_q;
	logic         found_dest_q;
	rob_ndx_t     dest_id_q;
	// streams to drop, shared by the front end and the ROB
	stream_mask_t squashed_streams;
	// ROB tags
	seqnum_t [ROB_ENTRIES-1:0] entry_seq;
	stream_t [ROB_ENTRIES-1:0] entry_stream;
	rob_mask_t                 entry_valid;

	miss_capture u_miss_capture (.*);

	// the closure starts from the latched wrong-path stream
	stream_dep_table #(
		.XSTREAMS      (XSTREAMS),
		.BRANCH_LEVELS (BRANCH_LEVELS)
	) u_stream_dep_table (
		.miss_stream (miss_stream_q),
		.*
	);

	rob_tag_store #(.ROB_ENTRIES(ROB_ENTRIES)) u_rob_tag_store (.*);

	frontend_stomp u_frontend_stomp (.*);

	rob_stomp #(.ROB_ENTRIES(ROB_ENTRIES)) u_rob_stomp (.*);

endmodule

// File: rob_stomp.sv
// the mask assumes sequence numbers do not wrap and that miss_id_q and dest_id_q name valid entries at the pulse
`timescale 1ns/10ps

module rob_stomp #(
	parameter int ROB_ENTRIES = stomp_pkg::ROB_ENTRIES
) (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  miss_pulse,
	input  logic                                  found_dest_q,
	input  stomp_pkg::rob_ndx_t                   miss_id_q,
	input  stomp_pkg::rob_ndx_t                   dest_id_q,
	input  stomp_pkg::stream_t                    miss_stream_q,
	input  stomp_pkg::stream_mask_t               squashed_streams,
	input  stomp_pkg::seqnum_t [ROB_ENTRIES-1:0] entry_seq,
	input  stomp_pkg::stream_t [ROB_ENTRIES-1:0] entry_stream,
	input  stomp_pkg::rob_mask_t                  entry_valid,
	output stomp_pkg::rob_mask_t                  rob_squash
);
	import stomp_pkg::*;

	seqnum_t   br_seq;
	seqnum_t   dst_seq;
	stream_t   br_stream;
	rob_mask_t hit;

	// tags of the branch and of the entry holding the target
	assign br_seq = entry_seq[miss_id_q];
	assign br_stream = entry_stream[miss_id_q];
	assign dst_seq = entry_seq[dest_id_q];

	// ====================================================================
	// per-entry squash decision
	// ====================================================================

	always_comb begin
		for (int n = 0; n < ROB_ENTRIES; n++) begin
			logic younger;
			logic between;
			logic on_wrong_path;
			younger = entry_seq[n] > br_seq;
			// the target is already in the ROB, only the gap before it goes
			between = younger && entry_seq[n] < dst_seq;
			// the wrong-path stream is matched directly, the closure adds
			// every stream that was forked from it
			on_wrong_path = (miss_stream_q != '0 && entry_stream[n] == miss_stream_q) ||
				squashed_streams[entry_stream[n]];
			if (found_dest_q)
				hit[n] = between;
			else
				hit[n] = younger && entry_stream[n] != br_stream;
			hit[n] = entry_valid[n] && (hit[n] || on_wrong_path);
		end
	end

	// the mask fans out widely, so it is registered and lasts one cycle
	always_ff @(posedge clk) begin
		if (rst)
			rob_squash <= '0;
		else if (miss_pulse)
			rob_squash <= hit;
		else
			rob_squash <= '0;
	end

endmodule

// File: frontend_stomp.sv
// stage pcs must be aligned, since the reset target is an odd address that no stage can match
`timescale 1ns/10ps

module frontend_stomp (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    advance,
	input  logic                    miss_pulse,
	input  logic                    found_dest_q,
	input  stomp_pkg::pc_t          miss_pc_q,
	input  stomp_pkg::stream_mask_t squashed_streams,
	input  stomp_pkg::pc_t          fet_pc,
	input  stomp_pkg::stream_t      fet_stream,
	input  stomp_pkg::pc_t          ext_pc,
	input  stomp_pkg::stream_t      ext_stream,
	input  stomp_pkg::pc_t          dec_pc,
	input  stomp_pkg::stream_t      dec_stream,
	input  stomp_pkg::pc_t          ren_pc,
	input  stomp_pkg::stream_t      ren_stream,
	output logic                    stomp_fet,
	output logic                    stomp_ext,
	output logic                    stomp_dec,
	output logic                    stomp_ren,
	output logic                    stomp_que
);
	import stomp_pkg::*;

	// fetch, extract, decode and rename, in pipeline order
	localparam int STAGES = 4;

	pc_t               target_pc;
	pc_t               stage_pc [STAGES];
	stream_t           stage_stream [STAGES];
	logic [STAGES-1:0] flag;
	logic [STAGES-1:0] squash;
	logic              arm;

	// only a miss without a ROB destination flushes the front end
	assign arm = miss_pulse && !found_dest_q;

	// index 0 is fetch, index 3 is rename
	always_comb begin
		stage_pc = '{fet_pc, ext_pc, dec_pc, ren_pc};
		stage_stream = '{fet_stream, ext_stream, dec_stream, ren_stream};
	end

	// ====================================================================
	// miss target and stage flags
	// ====================================================================

	// the front end keeps its own copy of the target, so a later miss that
	// found its destination leaves the running waterfall alone
	always_ff @(posedge clk) begin
		if (rst)
			target_pc <= NO_TARGET;
		else if (arm)
			target_pc <= miss_pc_q;
	end

	// all stages start flagged because the pipeline is empty after reset
	// a flag drops once the target group is seen in its stage on an advance
	always_ff @(posedge clk) begin
		if (rst) begin
			flag <= '1;
		end else begin
			for (int i = 0; i < STAGES; i++) begin
				if (arm)
					flag[i] <= 1'b1;
				else if (advance && stage_pc[i] == target_pc)
					flag[i] <= 1'b0;
			end
		end
	end

	// a flagged stage drops every group except the one at the target
	// squashed streams are dropped in any cycle, even when stalled
	always_comb begin
		for (int i = 0; i < STAGES; i++)
			squash[i] = (flag[i] && stage_pc[i] != target_pc) ||
				squashed_streams[stage_stream[i]];
	end

	assign stomp_fet = squash[0];
	assign stomp_ext = squash[1];
	assign stomp_dec = squash[2];
	assign stomp_ren = squash[3];

	// ====================================================================
	// queue stage
	// ====================================================================

	// a group in the queue stage is already renamed, so it is dropped one
	// advance after rename decided to drop it
	always_ff @(posedge clk) begin
		if (rst)
			stomp_que <= 1'b1;
		else if (advance)
			stomp_que <= squash[3];
	end

endmodule

// File: rob_tag_store.sv
// sequence numbers are not checked for wraparound, so fewer than 256 dispatches may happen between resets
`timescale 1ns/10ps

module rob_tag_store #(
	parameter int ROB_ENTRIES = stomp_pkg::ROB_ENTRIES
) (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  disp_valid,
	input  stomp_pkg::rob_ndx_t                   disp_id,
	input  stomp_pkg::stream_t                    disp_stream,
	input  logic                                  ret_valid,
	input  stomp_pkg::rob_ndx_t                   ret_id,
	output stomp_pkg::seqnum_t [ROB_ENTRIES-1:0] entry_seq,
	output stomp_pkg::stream_t [ROB_ENTRIES-1:0] entry_stream,
	output stomp_pkg::rob_mask_t                  entry_valid
);
	import stomp_pkg::*;

	// number given to the next dispatched entry
	seqnum_t next_seq;

	always_ff @(posedge clk) begin
		if (rst)
			next_seq <= '0;
		else if (disp_valid)
			next_seq <= next_seq + 1'b1;
	end

	// ====================================================================
	// valid bits
	// ====================================================================

	// a dispatch into the entry being retired wins, since the slot is refilled
	always_ff @(posedge clk) begin
		if (rst) begin
			entry_valid <= '0;
		end else begin
			if (ret_valid)
				entry_valid[ret_id] <= 1'b0;
			if (disp_valid)
				entry_valid[disp_id] <= 1'b1;
		end
	end

	// tags are only meaningful while the valid bit is set
	always_ff @(posedge clk) begin
		if (disp_valid) begin
			entry_seq[disp_id] <= next_seq;
			entry_stream[disp_id] <= disp_stream;
		end
	end

endmodule

// File: stream_dep_table.sv
// closure depth is limited to BRANCH_LEVELS steps, so deeper fork chains are only partly squashed
`timescale 1ns/10ps

module stream_dep_table #(
	parameter int XSTREAMS      = stomp_pkg::XSTREAMS,
	parameter int BRANCH_LEVELS = stomp_pkg::BRANCH_LEVELS
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    fork_valid,
	input  stomp_pkg::stream_t      fork_parent,
	input  stomp_pkg::stream_t      fork_child,
	input  logic                    free_valid,
	input  stomp_pkg::stream_t      free_stream,
	input  stomp_pkg::stream_t      miss_stream,
	input  logic                    miss_pulse,
	output stomp_pkg::stream_mask_t squashed_streams
);
	import stomp_pkg::*;

	// dep[p][c] is set while stream c is a live child forked from stream p
	stream_mask_t dep [XSTREAMS];
	stream_mask_t reach;
	stream_mask_t grow;

	// ====================================================================
	// closure of the missed stream
	// ====================================================================

	always_comb begin
		reach = '0;
		// stream 0 carries no fork tree and starts nothing
		if (miss_stream != '0)
			reach[miss_stream] = 1'b1;
		// each step adds the children of every stream reached so far
		for (int lvl = 0; lvl < BRANCH_LEVELS; lvl++) begin
			grow = reach;
			for (int s = 1; s < XSTREAMS; s++) begin
				if (reach[s])
					grow = grow | dep[s];
			end
			reach = grow;
		end
		reach[0] = 1'b0;
	end

	assign squashed_streams = reach;

	// ====================================================================
	// table updates
	// ====================================================================

	// later statements win, so a fork in the same cycle as a clear is kept
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < XSTREAMS; s++)
				dep[s] <= '0;
		end else begin
			// squashed streams lose their children so the ids can be reused
			if (miss_pulse) begin
				for (int s = 0; s < XSTREAMS; s++) begin
					if (reach[s])
						dep[s] <= '0;
				end
			end
			// a freed stream is no longer anyone's parent or child
			if (free_valid) begin
				dep[free_stream] <= '0;
				for (int s = 0; s < XSTREAMS; s++)
					dep[s][free_stream] <= 1'b0;
			end
			// stream 0 is never recorded as a child
			if (fork_valid && fork_child != '0 && fork_child != fork_parent)
				dep[fork_parent][fork_child] <= 1'b1;
		end
	end

endmodule

// File: miss_capture.sv
// the branch unit must hold the miss report stable until miss_ack rises, and a new request is only taken after miss_ack falls
`timescale 1ns/10ps

module miss_capture (
	input  logic                clk,
	input  logic                rst,
	input  logic                miss_req,
	input  stomp_pkg::rob_ndx_t miss_id,
	input  stomp_pkg::pc_t      miss_pc,
	input  stomp_pkg::stream_t  miss_stream,
	input  logic                found_destination,
	input  stomp_pkg::rob_ndx_t dest_id,
	output logic                miss_ack,
	output logic                miss_pulse,
	output stomp_pkg::rob_ndx_t miss_id_q,
	output stomp_pkg::pc_t      miss_pc_q,
	output stomp_pkg::stream_t  miss_stream_q,
	output logic                found_dest_q,
	output stomp_pkg::rob_ndx_t dest_id_q
);
	import stomp_pkg::*;

	miss_state_t state;
	logic take;

	// a request is only taken while the receiver is idle
	assign take = (state == idle) && miss_req;

	// ====================================================================
	// four-phase handshake
	// ====================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (miss_req)
						state <= capture;
				end
				// the report was latched on the last edge, ack goes up next
				capture: state <= ack_hi;
				// first ack cycle, this is also the single pulse cycle
				ack_hi: begin
					if (miss_req)
						state <= wait_drop;
					else
						state <= idle;
				end
				wait_drop: begin
					if (!miss_req)
						state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	// ack covers both states after capture, so it rises two cycles after req
	assign miss_ack = (state == ack_hi) || (state == wait_drop);
	// both squash paths start from this one-cycle strobe
	assign miss_pulse = (state == ack_hi);

	// the stream and the destination flag feed live logic, so they get a known value
	always_ff @(posedge clk) begin
		if (rst) begin
			miss_stream_q <= '0;
			found_dest_q <= 1'b0;
		end else if (take) begin
			miss_stream_q <= miss_stream;
			found_dest_q <= found_destination;
		end
	end

	// ids and target pc are only looked at on the pulse
	always_ff @(posedge clk) begin
		if (take) begin
			miss_id_q <= miss_id;
			miss_pc_q <= miss_pc;
			dest_id_q <= dest_id;
		end
	end

endmodule

// File: stomp_pkg.sv
// typedef widths are fixed to the default sizes below, so any change to the sizes must be made in both places
package stomp_pkg;

	// ====================================================================
	// default sizes
	// ====================================================================

	// number of re-order buffer entries
	parameter int ROB_ENTRIES = 16;
	// number of branch streams, stream 0 means no stream
	parameter int XSTREAMS = 8;
	// expansion steps taken when walking the fork tree of a missed stream
	parameter int BRANCH_LEVELS = 4;

	// ====================================================================
	// widths that carry a meaning
	// ====================================================================

	// index of one ROB entry
	typedef logic [3:0] rob_ndx_t;
	// one bit per ROB entry
	typedef logic [15:0] rob_mask_t;
	// dispatch order, wraparound is not handled
	typedef logic [7:0] seqnum_t;
	// branch stream id
	typedef logic [2:0] stream_t;
	// one bit per branch stream
	typedef logic [7:0] stream_mask_t;
	// instruction address
	typedef logic [31:0] pc_t;

	// the front end compares stage pcs against this after reset
	// an odd address is never fetched, so no stage ever matches it
	parameter pc_t NO_TARGET = 32'hFFFF_FFFF;

	// states of the miss report receiver
	typedef enum logic [1:0] {
		idle,
		capture,
		ack_hi,
		wait_drop
	} miss_state_t;

endpackage
